/* vlog.f */
hdl/sys86_pkg.sv
hdl/cus41_decode.sv
hdl/vblank_irq_watchdog.sv
hdl/tile_layer_latch.sv
hdl/main_bus_ctrl.sv
bench/main_bus_ctrl_assert.sv
bench/main_bus_ctrl_tb.sv

/* Bender.yml */
package:
  name: main_bus_ctrl

sources:
  - hdl/sys86_pkg.sv
  - hdl/cus41_decode.sv
  - hdl/vblank_irq_watchdog.sv
  - hdl/tile_layer_latch.sv
  - hdl/main_bus_ctrl.sv
  - target: test
    files:
      - bench/main_bus_ctrl_assert.sv
      - bench/main_bus_ctrl_tb.sv

/* bench/main_bus_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl_tb;

	import sys86_pkg::*;

	// One decode vector with its expected strobes
	typedef struct packed {
		logic [15:0] addr;
		logic        we;
		logic [7:0]  data;
		chip_sel_t   exp;
	} dec_vec_t;

	logic        clk_6m;
	logic        reset;
	bus_req_t    bus;
	logic        vblk;
	chip_sel_t   cs;
	logic        sint;
	logic        mreset;
	layer_regs_t layer0;
	layer_regs_t layer1;

	int errors;
	int checks;
	int tests_run;
	int tests_bad;
	int errors_at_start;

	// Boundary addresses of the main CPU map
	logic [15:0] edge_addr [11] = '{16'h0000, 16'h1fff, 16'h2000, 16'h5fff, 16'h6000,
		16'h7fff, 16'h8000, 16'h8800, 16'hd000, 16'hd800, 16'hffff};
	// Data for the latch writes with bank 0 ahead of bank 1
	logic [7:0]  lth_data [14] = '{8'h3c, 8'h81, 8'h47, 8'h0a, 8'hc5, 8'h96, 8'h2e,
		8'h5b, 8'he0, 8'h19, 8'h73, 8'ha4, 8'h6d, 8'hf2};
	dec_vec_t    dec_tab [22];
	dec_vec_t    lth_tab [16];

	main_bus_ctrl #(
		.watchdog_width (4)
	) i_main_bus_ctrl (
		.clk_6m (clk_6m),
		.reset  (reset),
		.bus    (bus),
		.vblk   (vblk),
		.cs     (cs),
		.sint   (sint),
		.mreset (mreset),
		.layer0 (layer0),
		.layer1 (layer1)
	);

	always #2 clk_6m = ~clk_6m;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Strobe expected for one valid cycle
	function automatic chip_sel_t expect_cs(input logic [15:0] addr, input logic we);
		chip_sel_t  e;
		logic [4:0] pg;
		e = '0;
		pg = addr[15:11];
		if (addr < 16'h2000) begin
			e.mcs2 = 1'b1;
		end else if (addr < 16'h4000) begin
			e.mcs0 = 1'b1;
		end else if (addr < 16'h6000) begin
			e.mcs1 = 1'b1;
		end else if (addr < 16'h8000) begin
			e.mcs4 = !we;
		end else if (!we) begin
			e.mrom = 1'b1;
		end else begin
			// Control pages inside ROM space, writes only
			e.wdog_kick = (pg == map_wdog_kick);
			e.irq_ack   = (pg == map_irq_ack);
			e.lth0      = (pg == map_lth0);
			e.lth1      = (pg == map_lth1);
		end
		return e;
	endfunction

	// Offset 0 is the top byte of the struct
	// Offset 7 has no register
	function automatic layer_regs_t put_byte(input layer_regs_t r, input logic [2:0] off,
		input logic [7:0] d);
		layer_regs_t n;
		int          lsb;
		n = r;
		lsb = 48 - 8 * int'(off);
		if (off != 3'd7) begin
			n[lsb +: 8] = d;
		end
		return n;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_idle();
		bus = '0;
	endtask

	task automatic apply_reset();
		@(negedge clk_6m);
		reset = 1'b1;
		vblk = 1'b0;
		bus_idle();
		repeat (8) @(negedge clk_6m);
		reset = 1'b0;
	endtask

	// Drive one bus cycle and return once its strobe is visible
	task automatic bus_cycle(input logic [15:0] addr, input logic we, input logic [7:0] data);
		@(negedge clk_6m);
		bus.valid = 1'b1;
		bus.addr = addr;
		bus.we = we;
		bus.data = data;
		@(negedge clk_6m);
		bus_idle();
		@(negedge clk_6m);
	endtask

	// Poll sint or mreset until it reaches the level
	task automatic wait_level(input bit pick_mreset, input logic level, input int limit);
		int   n;
		logic now;
		n = 0;
		now = pick_mreset ? mreset : sint;
		while (now !== level && n < limit) begin
			@(negedge clk_6m);
			n++;
			now = pick_mreset ? mreset : sint;
		end
		if (now !== level) begin
			$display("timeout: %s did not reach %0d within %0d cycles",
				pick_mreset ? "mreset" : "sint", level, limit);
			errors++;
		end
	endtask

	task automatic vblank_pulse();
		@(negedge clk_6m);
		vblk = 1'b1;
		repeat (3) @(negedge clk_6m);
		vblk = 1'b0;
		repeat (3) @(negedge clk_6m);
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		chip_sel_t   exp_q [$];
		chip_sel_t   e;
		layer_regs_t exp0;
		layer_regs_t exp1;
		bus_req_t    r;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_bad = 0;
		errors_at_start = 0;
		clk_6m = 1'b0;
		reset = 1'b1;
		vblk = 1'b0;
		bus = '0;
		void'($urandom(85560));
		// Each boundary as a read and then as a write
		for (int i = 0; i < 11; i++) begin
			for (int w = 0; w < 2; w++) begin
				dec_tab[2*i+w].addr = edge_addr[i];
				dec_tab[2*i+w].we = w[0];
				dec_tab[2*i+w].data = 8'h5a ^ 8'(i);
				dec_tab[2*i+w].exp = expect_cs(edge_addr[i], w[0]);
			end
		end
		// Latch writes followed by offset 7 and a read of D000h
		for (int i = 0; i < 14; i++) begin
			lth_tab[i].addr = (i < 7) ? 16'hd000 + 16'(i) : 16'hd800 + 16'(i - 7);
			lth_tab[i].we = 1'b1;
			lth_tab[i].data = lth_data[i];
			lth_tab[i].exp = expect_cs(lth_tab[i].addr, 1'b1);
		end
		lth_tab[14] = '{16'hd007, 1'b1, 8'hff, expect_cs(16'hd007, 1'b1)};
		lth_tab[15] = '{16'hd000, 1'b0, 8'h77, expect_cs(16'hd000, 1'b0)};

		repeat (8) @(negedge clk_6m);
		reset = 1'b0;

		// 1 Reset state
		@(negedge clk_6m);
		check_value("cs", 64'(cs), 64'h0);
		check_value("sint", 64'(sint), 64'h0);
		check_value("mreset", 64'(mreset), 64'h0);
		check_value("layer0", 64'(layer0), 64'h0);
		check_value("layer1", 64'(layer1), 64'h0);
		end_test(1, "reset state");

		// 2 Boundary table followed by random cycles back to back
		foreach (dec_tab[i]) begin
			bus_cycle(dec_tab[i].addr, dec_tab[i].we, dec_tab[i].data);
			check_value("cs", 64'(cs), 64'(dec_tab[i].exp));
		end
		for (int i = 0; i < 66; i++) begin
			@(negedge clk_6m);
			// Strobe of the cycle driven two falling edges ago
			if (i >= 2) begin
				e = exp_q.pop_front();
				check_value("cs", 64'(cs), 64'(e));
			end
			if (i < 64) begin
				r.valid = ($urandom_range(0, 3) != 0);
				r.addr = 16'($urandom_range(0, 16'hffff));
				r.we = 1'($urandom_range(0, 1));
				r.data = 8'($urandom_range(0, 255));
				bus = r;
				exp_q.push_back(r.valid ? expect_cs(r.addr, r.we) : chip_sel_t'('0));
			end else begin
				bus_idle();
			end
		end
		end_test(2, "address decode");

		// 3 Latch banks
		apply_reset();
		exp0 = '0;
		exp1 = '0;
		foreach (lth_tab[i]) begin
			bus_cycle(lth_tab[i].addr, lth_tab[i].we, lth_tab[i].data);
			check_value("cs", 64'(cs), 64'(lth_tab[i].exp));
			@(negedge clk_6m);
			if (lth_tab[i].we && lth_tab[i].addr[15:11] == map_lth0) begin
				exp0 = put_byte(exp0, lth_tab[i].addr[2:0], lth_tab[i].data);
			end
			if (lth_tab[i].we && lth_tab[i].addr[15:11] == map_lth1) begin
				exp1 = put_byte(exp1, lth_tab[i].addr[2:0], lth_tab[i].data);
			end
			check_value("layer0", 64'(layer0), 64'(exp0));
			check_value("layer1", 64'(layer1), 64'(exp1));
		end
		end_test(3, "latch writes");

		// 4 Vertical blank interrupt
		apply_reset();
		@(negedge clk_6m);
		vblk = 1'b1;
		wait_level(1'b0, 1'b1, 8);
		repeat (3) vblank_pulse();
		check_value("sint", 64'(sint), 64'h1);
		bus_cycle(16'h8800, 1'b1, 8'h00);
		check_value("cs", 64'(cs), 64'(expect_cs(16'h8800, 1'b1)));
		wait_level(1'b0, 1'b0, 4);
		// Set sint again and land a rise on the acknowledge edge
		@(negedge clk_6m);
		vblk = 1'b1;
		wait_level(1'b0, 1'b1, 8);
		vblk = 1'b0;
		repeat (3) @(negedge clk_6m);
		bus.valid = 1'b1;
		bus.addr = 16'h8800;
		bus.we = 1'b1;
		@(negedge clk_6m);
		bus_idle();
		vblk = 1'b1;
		@(negedge clk_6m);
		check_value("cs.irq_ack", 64'(cs.irq_ack), 64'h1);
		repeat (4) begin
			@(negedge clk_6m);
			check_value("sint", 64'(sint), 64'h1);
		end
		vblk = 1'b0;
		end_test(4, "interrupt");

		// 5 Watchdog of width 4 trips on the 8th blank
		apply_reset();
		for (int p = 1; p < 8; p++) begin
			vblank_pulse();
			check_value("mreset", 64'(mreset), 64'h0);
		end
		vblank_pulse();
		wait_level(1'b1, 1'b1, 8);
		apply_reset();
		for (int p = 0; p < 20; p++) begin
			vblank_pulse();
			bus_cycle(16'h8000, 1'b1, 8'h00);
			check_value("cs", 64'(cs), 64'(expect_cs(16'h8000, 1'b1)));
			check_value("mreset", 64'(mreset), 64'h0);
		end
		end_test(5, "watchdog");

		$display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Hard stop in case a wait never ends
	initial begin
		#200000;
		$display("simulation time limit reached, run stopped");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/main_bus_ctrl_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl_assert (
	input wire                      clk_6m,
	input wire                      reset,
	input wire sys86_pkg::bus_req_t bus,
	input wire sys86_pkg::chip_sel_t cs,
	input wire                      sint,
	input wire                      mreset
);

	////////////////////////////////////////////////////////////////////////////
	// Chip select strobes
	////////////////////////////////////////////////////////////////////////////

	// One region per cycle at most
	a_cs_onehot: assert property (@(posedge clk_6m) $onehot0(cs))
		else $error("more than one chip select active");

	// Strobe seen at an edge comes from the cycle sampled two edges before
	a_cs_single: assert property (@(posedge clk_6m) disable iff (reset)
		|(cs & $past(cs)) |-> ($past(bus.valid, 2) && $past(bus.valid, 3)))
		else $error("chip select held for two cycles without two bus cycles");

	////////////////////////////////////////////////////////////////////////////
	// Reset outputs
	////////////////////////////////////////////////////////////////////////////

	a_sint_reset: assert property (@(posedge clk_6m) $past(reset) |-> !sint)
		else $error("sint high during reset");

	a_mreset_reset: assert property (@(posedge clk_6m) $past(reset) |-> !mreset)
		else $error("mreset high during reset");

endmodule

bind main_bus_ctrl main_bus_ctrl_assert i_main_bus_ctrl_assert (
	.clk_6m (clk_6m),
	.reset  (reset),
	.bus    (bus),
	.cs     (cs),
	.sint   (sint),
	.mreset (mreset)
);

`default_nettype wire

/* hdl/main_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl #(
	parameter int watchdog_width = 8
) (
	input  wire                      clk_6m,
	input  wire                      reset,
	input  wire sys86_pkg::bus_req_t bus,
	input  wire                      vblk,
	output sys86_pkg::chip_sel_t     cs,
	output logic                     sint,
	output logic                     mreset,
	output sys86_pkg::layer_regs_t   layer0,
	output sys86_pkg::layer_regs_t   layer1
);

	// Latch payload shared by both banks
	logic [2:0] wr_offset;
	logic [7:0] wr_data;

	////////////////////////////////////////////////////////////////////////////
	// Decode and control
	////////////////////////////////////////////////////////////////////////////

	cus41_decode i_cus41_decode (
		.clk_6m    (clk_6m),
		.reset     (reset),
		.bus       (bus),
		.cs        (cs),
		.wr_offset (wr_offset),
		.wr_data   (wr_data)
	);

	vblank_irq_watchdog #(
		.watchdog_width (watchdog_width)
	) i_vblank_irq_watchdog (
		.clk_6m    (clk_6m),
		.reset     (reset),
		.vblk      (vblk),
		.irq_ack   (cs.irq_ack),
		.wdog_kick (cs.wdog_kick),
		.sint      (sint),
		.mreset    (mreset)
	);

	////////////////////////////////////////////////////////////////////////////
	// Tile layer latches
	////////////////////////////////////////////////////////////////////////////

	// Bank 0 at D000h
	tile_layer_latch i_tile_layer_latch_0 (
		.clk_6m    (clk_6m),
		.reset     (reset),
		.wr_en     (cs.lth0),
		.wr_offset (wr_offset),
		.wr_data   (wr_data),
		.regs      (layer0)
	);

	// Bank 1 at D800h
	tile_layer_latch i_tile_layer_latch_1 (
		.clk_6m    (clk_6m),
		.reset     (reset),
		.wr_en     (cs.lth1),
		.wr_offset (wr_offset),
		.wr_data   (wr_data),
		.regs      (layer1)
	);

endmodule

`default_nettype wire

/* hdl/tile_layer_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_layer_latch (
	input  wire                    clk_6m,
	input  wire                    reset,
	input  wire                    wr_en,
	input  wire [2:0]              wr_offset,
	input  wire [7:0]              wr_data,
	output sys86_pkg::layer_regs_t regs
);

	import sys86_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Register bank
	////////////////////////////////////////////////////////////////////////////

	// Offsets 0 to 2 are layer A scroll and priority
	// Offset 3 picks the ROM bank
	// Offsets 4 to 6 are layer B scroll and priority
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			regs <= '0;
		end else if (wr_en) begin
			case (wr_offset)
				off_pri_xhi_a: begin
					regs.pri_xhi_a <= wr_data;
				end
				off_scroll_x_a: begin
					regs.scroll_x_a <= wr_data;
				end
				off_scroll_y_a: begin
					regs.scroll_y_a <= wr_data;
				end
				off_rom_bank: begin
					regs.rom_bank <= wr_data;
				end
				off_pri_xhi_b: begin
					regs.pri_xhi_b <= wr_data;
				end
				off_scroll_x_b: begin
					regs.scroll_x_b <= wr_data;
				end
				off_scroll_y_b: begin
					regs.scroll_y_b <= wr_data;
				end
				default: begin
					// Offset 7 has no register behind it
					regs <= regs;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/vblank_irq_watchdog.sv */
`timescale 1ns/1ps
`default_nettype none

module vblank_irq_watchdog #(
	parameter int watchdog_width = 8
) (
	input  wire  clk_6m,
	input  wire  reset,
	input  wire  vblk,
	input  wire  irq_ack,
	input  wire  wdog_kick,
	output logic sint,
	output logic mreset
);

	logic                      vblk_q;     // Current vblk sample
	logic                      vblk_qq;    // Previous vblk sample
	logic                      vblk_rise;
	logic [watchdog_width-1:0] wdog_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Vertical blank edge detect
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			vblk_q  <= 1'b0;
			vblk_qq <= 1'b0;
		end else begin
			vblk_q  <= vblk;
			vblk_qq <= vblk_q;
		end
	end

	// High for one cycle after a new blank is sampled
	assign vblk_rise = vblk_q & ~vblk_qq;

	////////////////////////////////////////////////////////////////////////////
	// Interrupt latch
	////////////////////////////////////////////////////////////////////////////

	// Set beats clear when both land together
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			sint <= 1'b0;
		end else if (vblk_rise) begin
			sint <= 1'b1;
		end else if (irq_ack) begin
			sint <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////////////////////

	// Counts blanks since the last kick
	// Rolls over to zero past the all-ones value
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			wdog_cnt <= '0;
		end else if (wdog_kick) begin
			wdog_cnt <= '0;
		end else if (vblk_rise) begin
			wdog_cnt <= wdog_cnt + 1'b1;
		end
	end

	// Reset request once half the count range is used up
	assign mreset = wdog_cnt[watchdog_width-1];

endmodule

`default_nettype wire

/* hdl/cus41_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cus41_decode (
	input  wire                  clk_6m,
	input  wire                  reset,
	input  wire sys86_pkg::bus_req_t bus,
	output sys86_pkg::chip_sel_t cs,
	output logic [2:0]           wr_offset,
	output logic [7:0]           wr_data
);

	import sys86_pkg::*;

	bus_req_t   bus_q;   // Cycle captured at the first edge
	logic [4:0] page;    // 2K page of the captured address
	region_e    region;

	////////////////////////////////////////////////////////////////////////////
	// Input stage
	////////////////////////////////////////////////////////////////////////////

	// Capture the CPU cycle at the first edge
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			bus_q.valid <= 1'b0;
		end else begin
			bus_q <= bus;
		end
	end

	assign page = bus_q.addr[15:11];

	////////////////////////////////////////////////////////////////////////////
	// Region decode
	////////////////////////////////////////////////////////////////////////////

	// RAM windows answer both directions
	// ROM windows answer reads and control pages answer writes
	always_comb begin
		region = reg_none;
		if (bus_q.valid) begin
			if (page < map_vram1_lo) begin
				region = reg_spr_ram;
			end else if (page < map_vram2_lo) begin
				region = reg_vram1;
			end else if (page < map_bank_rom_lo) begin
				region = reg_vram2;
			end else if (page < map_main_rom_lo) begin
				// Writes into bank ROM go nowhere
				region = bus_q.we ? reg_none : reg_bank_rom;
			end else if (!bus_q.we) begin
				region = reg_main_rom;
			end else if (page == map_wdog_kick) begin
				region = reg_wdog_kick;
			end else if (page == map_irq_ack) begin
				region = reg_irq_ack;
			end else if (page == map_lth0) begin
				region = reg_lth0;
			end else if (page == map_lth1) begin
				region = reg_lth1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobe stage
	////////////////////////////////////////////////////////////////////////////

	// One-hot strobes for a single cycle
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			cs <= '0;
		end else begin
			cs <= '0;
			case (region)
				reg_spr_ram:   cs.mcs2      <= 1'b1;
				reg_vram1:     cs.mcs0      <= 1'b1;
				reg_vram2:     cs.mcs1      <= 1'b1;
				reg_bank_rom:  cs.mcs4      <= 1'b1;
				reg_main_rom:  cs.mrom      <= 1'b1;
				reg_wdog_kick: cs.wdog_kick <= 1'b1;
				reg_irq_ack:   cs.irq_ack   <= 1'b1;
				reg_lth0:      cs.lth0      <= 1'b1;
				reg_lth1:      cs.lth1      <= 1'b1;
				default:       cs           <= '0;
			endcase
		end
	end

	// Latch payload travels alongside the strobe
	always_ff @(posedge clk_6m) begin
		wr_offset <= bus_q.addr[2:0];
		wr_data   <= bus_q.data;
	end

endmodule

`default_nettype wire

/* hdl/sys86_pkg.sv */
`default_nettype none

package sys86_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Main CPU bus
	////////////////////////////////////////////////////////////////////////////

	// One main CPU cycle, presented for a single clock
	typedef struct packed {
		logic        valid;  // Cycle strobe
		logic [15:0] addr;
		logic        we;     // High for a write
		logic [7:0]  data;   // Write data
	} bus_req_t;

	// Decoded region of one cycle
	typedef enum logic [3:0] {
		reg_none,
		reg_spr_ram,
		reg_vram1,
		reg_vram2,
		reg_bank_rom,
		reg_main_rom,
		reg_wdog_kick,
		reg_irq_ack,
		reg_lth0,
		reg_lth1
	} region_e;

	// Registered one-cycle chip selects
	typedef struct packed {
		logic mcs2;       // Sprite RAM
		logic mcs0;       // Video RAM 1
		logic mcs1;       // Video RAM 2
		logic mcs4;       // Bank ROM read
		logic mrom;       // Main ROM read
		logic wdog_kick;
		logic irq_ack;
		logic lth0;       // Tile layer latch bank 0
		logic lth1;       // Tile layer latch bank 1
	} chip_sel_t;

	// Contents of one tile layer latch bank, in offset order
	typedef struct packed {
		logic [7:0] pri_xhi_a;
		logic [7:0] scroll_x_a;
		logic [7:0] scroll_y_a;
		logic [7:0] rom_bank;
		logic [7:0] pri_xhi_b;
		logic [7:0] scroll_x_b;
		logic [7:0] scroll_y_b;
	} layer_regs_t;

	////////////////////////////////////////////////////////////////////////////
	// Address map on addr[15:11]
	////////////////////////////////////////////////////////////////////////////

	// Lower bounds of the RAM and ROM windows
	localparam logic [4:0] map_vram1_lo    = 5'b00100;  // 2000h
	localparam logic [4:0] map_vram2_lo    = 5'b01000;  // 4000h
	localparam logic [4:0] map_bank_rom_lo = 5'b01100;  // 6000h
	localparam logic [4:0] map_main_rom_lo = 5'b10000;  // 8000h

	// Write-only control pages inside the ROM space
	localparam logic [4:0] map_wdog_kick   = 5'b10000;  // 8000h
	localparam logic [4:0] map_irq_ack     = 5'b10001;  // 8800h
	localparam logic [4:0] map_lth0        = 5'b11010;  // D000h
	localparam logic [4:0] map_lth1        = 5'b11011;  // D800h

	// Latch register offsets on addr[2:0]
	localparam logic [2:0] off_pri_xhi_a  = 3'd0;
	localparam logic [2:0] off_scroll_x_a = 3'd1;
	localparam logic [2:0] off_scroll_y_a = 3'd2;
	localparam logic [2:0] off_rom_bank   = 3'd3;
	localparam logic [2:0] off_pri_xhi_b  = 3'd4;
	localparam logic [2:0] off_scroll_x_b = 3'd5;
	localparam logic [2:0] off_scroll_y_b = 3'd6;

endpackage

`default_nettype wire
